/* common/calc_pkg.sv */
`default_nettype none

package calc_pkg;

    localparam int VALUE_W   = 20;      // Operand and result width
    localparam int MAX_VALUE = 999999;  // Largest value on six digits
    localparam int DIGITS    = 6;

    // Keypad codes above the digits, subtract and multiply sit between add and divide
    localparam logic [3:0] KEY_ADD = 4'd10;
    localparam logic [3:0] KEY_DIV = 4'd13;
    localparam logic [3:0] KEY_CLR = 4'd14;
    localparam logic [3:0] KEY_EQ  = 4'd15;

    typedef struct packed {
        logic [3:0] code;               // Row * 4 + column
    } key_t;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_DIV
    } op_t;

    typedef struct packed {
        logic [VALUE_W-1:0] magnitude;
        logic               negative;
        logic               error;      // Overflow or divide by zero
    } result_t;

endpackage

`default_nettype wire

/* src/tick_timer.sv */
`default_nettype none

module tick_timer #(
    parameter int TICK_CYCLES = 50000
) (
    input  logic sys_clk,
    input  logic rst_n,
    output logic tick
);
    localparam int CNT_W = $clog2(TICK_CYCLES + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == CNT_W'(TICK_CYCLES - 1)) begin
            cnt  <= '0;
            tick <= 1'b1;           // One pulse per wrap
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* keypad/key_scan.sv */
`default_nettype none

module key_scan #(
    parameter int DEBOUNCE_TICKS = 20
) (
    input  logic           sys_clk,
    input  logic           rst_n,
    input  logic           tick,
    input  logic [3:0]     row_in,
    output logic [3:0]     col_out,
    output logic           key_valid,
    output calc_pkg::key_t key
);
    localparam int CNT_W = $clog2(DEBOUNCE_TICKS + 1);

    typedef enum logic [1:0] {S_SCAN, S_PRESS, S_HELD} state_t;

    state_t           state;
    logic [3:0]       row_meta;
    logic [3:0]       row_sync;         // Synchronized rows
    logic [3:0]       row_seen;         // Pattern under debounce
    logic [1:0]       col_idx;
    logic [1:0]       row_idx;
    logic [CNT_W-1:0] cnt;

    // Lowest low row wins if several are pressed
    always_comb begin
        row_idx = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (!row_seen[i]) row_idx = 2'(i);
        end
    end

    assign col_out = ~(4'b0001 << col_idx);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            row_meta  <= 4'hf;
            row_sync  <= 4'hf;
            state     <= S_SCAN;
            col_idx   <= 2'd0;
            cnt       <= '0;
            key_valid <= 1'b0;
        end else begin
            row_meta  <= row_in;
            row_sync  <= row_meta;
            key_valid <= 1'b0;
            if (tick) begin
                case (state)
                    S_SCAN: begin
                        if (row_sync != 4'hf) begin
                            row_seen <= row_sync;
                            cnt      <= '0;
                            state    <= S_PRESS;    // Column stays put
                        end else begin
                            col_idx <= col_idx + 2'd1;
                        end
                    end
                    S_PRESS: begin
                        if (row_sync != row_seen) begin
                            state <= S_SCAN;        // Bounce, start over
                        end else if (cnt == CNT_W'(DEBOUNCE_TICKS - 1)) begin
                            key_valid <= 1'b1;
                            key.code  <= {row_idx, col_idx};
                            cnt       <= '0;
                            state     <= S_HELD;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    S_HELD: begin
                        if (row_sync != 4'hf) begin
                            cnt <= '0;              // Still held
                        end else if (cnt == CNT_W'(DEBOUNCE_TICKS - 1)) begin
                            state <= S_SCAN;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    default: state <= S_SCAN;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* src/calc_ctrl.sv */
`default_nettype none

module calc_ctrl (
    input  logic                         sys_clk,
    input  logic                         rst_n,
    input  logic                         key_valid,
    input  calc_pkg::key_t               key,
    output logic                         start,
    output logic [calc_pkg::VALUE_W-1:0] operand_a,
    output logic [calc_pkg::VALUE_W-1:0] operand_b,
    output calc_pkg::op_t                op,
    input  logic                         done,
    input  calc_pkg::result_t            result,
    output calc_pkg::result_t            disp
);
    localparam int W  = calc_pkg::VALUE_W;
    localparam int EW = W + 4;          // Room for one more digit

    typedef enum logic [2:0] {S_FIRST, S_OP_SET, S_SECOND, S_WAIT, S_RESULT} state_t;

    state_t        state;
    logic [3:0]    code;
    logic          is_digit;
    logic          is_op;
    logic [W-1:0]  entry;               // Operand being typed
    logic [EW-1:0] shifted;
    logic          fits;

    assign code     = key.code;
    assign is_digit = (code <= 4'd9);
    assign is_op    = (code >= calc_pkg::KEY_ADD) && (code <= calc_pkg::KEY_DIV);
    assign entry    = (state == S_SECOND) ? operand_b : operand_a;
    assign shifted  = EW'(entry) * EW'(10) + EW'(code);
    assign fits     = (shifted <= EW'(calc_pkg::MAX_VALUE));

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state     <= S_FIRST;
            start     <= 1'b0;
            operand_a <= '0;
            operand_b <= '0;
            op        <= calc_pkg::OP_ADD;
            disp      <= '0;
        end else begin
            start <= 1'b0;
            if (state == S_WAIT) begin
                if (done) begin
                    disp  <= result;
                    state <= S_RESULT;
                end
            end else if (key_valid) begin
                if (code == calc_pkg::KEY_CLR) begin
                    state     <= S_FIRST;
                    operand_a <= '0;
                    operand_b <= '0;
                    op        <= calc_pkg::OP_ADD;
                    disp      <= '0;
                end else if (is_digit) begin
                    case (state)
                        S_FIRST: if (fits) operand_a <= shifted[W-1:0];
                        S_SECOND: if (fits) operand_b <= shifted[W-1:0];
                        S_OP_SET: begin
                            operand_b <= W'(code);
                            state     <= S_SECOND;
                        end
                        default: begin
                            operand_a <= W'(code);  // Fresh entry after a result
                            state     <= S_FIRST;
                        end
                    endcase
                    if (fits || state == S_OP_SET || state == S_RESULT)
                        disp <= '{magnitude: (state == S_OP_SET || state == S_RESULT)
                                             ? W'(code) : shifted[W-1:0],
                                  negative: 1'b0, error: 1'b0};
                end else if (is_op) begin
                    if (state != S_RESULT || !disp.error) begin
                        op <= calc_pkg::op_t'(2'(code - calc_pkg::KEY_ADD));
                        if (state == S_RESULT) operand_a <= disp.magnitude;
                        if (state != S_SECOND) state <= S_OP_SET;
                    end
                end else if (code == calc_pkg::KEY_EQ && state == S_SECOND) begin
                    start <= 1'b1;
                    state <= S_WAIT;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/calc_alu.sv */
`default_nettype none

module calc_alu (
    input  logic                         sys_clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [calc_pkg::VALUE_W-1:0] operand_a,
    input  logic [calc_pkg::VALUE_W-1:0] operand_b,
    input  calc_pkg::op_t                op,
    output logic                         done,
    output calc_pkg::result_t            result
);
    localparam int W  = calc_pkg::VALUE_W;
    localparam int PW = 2 * W;          // Holds the full product

    logic          s1_valid;
    logic [PW-1:0] s1_value;
    logic          s1_neg;
    logic          s1_div0;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= start;
            done     <= s1_valid;
        end
    end

    // Compute stage
    always_ff @(posedge sys_clk) begin
        if (start) begin
            s1_neg  <= 1'b0;
            s1_div0 <= 1'b0;
            case (op)
                calc_pkg::OP_ADD: s1_value <= PW'(operand_a) + PW'(operand_b);
                calc_pkg::OP_SUB: begin
                    if (operand_a >= operand_b) begin
                        s1_value <= PW'(operand_a - operand_b);
                    end else begin
                        s1_value <= PW'(operand_b - operand_a);
                        s1_neg   <= 1'b1;
                    end
                end
                calc_pkg::OP_MUL: s1_value <= PW'(operand_a) * PW'(operand_b);
                default: begin
                    s1_div0  <= (operand_b == '0);
                    s1_value <= (operand_b == '0) ? '0 : PW'(operand_a / operand_b);
                end
            endcase
        end
    end

    // Flag stage
    always_ff @(posedge sys_clk) begin
        if (s1_valid) begin
            result.magnitude <= s1_value[W-1:0];
            result.negative  <= s1_neg;
            result.error     <= s1_div0 || (s1_value > PW'(calc_pkg::MAX_VALUE));
        end
    end

endmodule

`default_nettype wire

/* display/seg_display.sv */
`default_nettype none

module seg_display (
    input  logic              sys_clk,
    input  logic              rst_n,
    input  logic              tick,
    input  calc_pkg::result_t disp,
    output logic [2:0]        sel,
    output logic [7:0]        seg
);
    localparam int W  = calc_pkg::VALUE_W;
    localparam int N  = calc_pkg::DIGITS;
    localparam int BW = 4 * N;
    localparam int SW = $clog2(W + 1);

    localparam logic [7:0] SEG_BLANK = 8'hff;
    localparam logic [7:0] SEG_MINUS = 8'hbf;
    localparam logic [7:0] SEG_E     = 8'h86;

    calc_pkg::result_t snap;            // Value under conversion
    logic [BW+W-1:0]   work;            // BCD digits above the binary part
    logic [SW-1:0]     steps;
    logic              busy;
    logic [BW-1:0]     digits;          // Last whole conversion
    logic              neg_q;
    logic              err_q;
    logic [2:0]        top;             // Highest nonzero digit
    logic [2:0]        sel_next;
    logic [3:0]        cur;

    function automatic logic [BW+W-1:0] dabble(input logic [BW+W-1:0] v);
        logic [BW+W-1:0] t;
        t = v;
        for (int i = 0; i < N; i++) begin
            if (t[W+4*i +: 4] >= 4'd5) t[W+4*i +: 4] = t[W+4*i +: 4] + 4'd3;
        end
        return t << 1;
    endfunction

    function automatic logic [7:0] seg_code(input logic [3:0] d);
        case (d)
            4'd0: return 8'hc0;
            4'd1: return 8'hf9;
            4'd2: return 8'ha4;
            4'd3: return 8'hb0;
            4'd4: return 8'h99;
            4'd5: return 8'h92;
            4'd6: return 8'h82;
            4'd7: return 8'hf8;
            4'd8: return 8'h80;
            4'd9: return 8'h90;
            default: return SEG_BLANK;
        endcase
    endfunction

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            snap   <= '0;
            busy   <= 1'b0;
            digits <= '0;
            neg_q  <= 1'b0;
            err_q  <= 1'b0;
        end else if (disp != snap) begin
            snap  <= disp;                  // Restart on any change
            work  <= {{BW{1'b0}}, disp.magnitude};
            steps <= '0;
            busy  <= 1'b1;
        end else if (busy) begin
            if (steps == SW'(W)) begin
                digits <= work[BW+W-1:W];
                neg_q  <= snap.negative;
                err_q  <= snap.error;
                busy   <= 1'b0;
            end else begin
                work  <= dabble(work);
                steps <= steps + 1'b1;
            end
        end
    end

    always_comb begin
        top = 3'd0;
        for (int i = 1; i < N; i++) begin
            if (digits[4*i +: 4] != 4'd0) top = 3'(i);
        end
    end

    assign sel_next = (sel == 3'(N - 1)) ? 3'd0 : sel + 3'd1;
    assign cur      = digits[4*sel_next +: 4];

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            sel <= 3'd0;
            seg <= SEG_BLANK;
        end else if (tick) begin
            sel <= sel_next;
            if (err_q) seg <= (sel_next == 3'd0) ? SEG_E : SEG_BLANK;
            else if (sel_next <= top) seg <= seg_code(cur);
            else if (neg_q && sel_next == top + 3'd1) seg <= SEG_MINUS;
            else seg <= SEG_BLANK;          // Leading zero
        end
    end

endmodule

`default_nettype wire

/* src/beep_driver.sv */
`default_nettype none

module beep_driver #(
    parameter int BEEP_TICKS  = 100,
    parameter int TONE_CYCLES = 12500
) (
    input  logic sys_clk,
    input  logic rst_n,
    input  logic tick,
    input  logic key_valid,
    output logic beep
);
    localparam int BW = $clog2(BEEP_TICKS + 1);
    localparam int TW = $clog2(TONE_CYCLES + 1);

    logic [BW-1:0] burst;               // Ticks left in the burst
    logic [TW-1:0] tone_cnt;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            burst <= '0;
        end else if (key_valid) begin
            burst <= BW'(BEEP_TICKS);   // New key restarts
        end else if (tick && burst != '0) begin
            burst <= burst - 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n || burst == '0) begin
            tone_cnt <= '0;
            beep     <= 1'b0;
        end else if (tone_cnt == TW'(TONE_CYCLES - 1)) begin
            tone_cnt <= '0;
            beep     <= ~beep;
        end else begin
            tone_cnt <= tone_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/calculator_top.sv */
`default_nettype none

module calculator_top #(
    parameter int TICK_CYCLES    = 50000,   // 1 ms at 50 MHz
    parameter int DEBOUNCE_TICKS = 20,
    parameter int BEEP_TICKS     = 100,
    parameter int TONE_CYCLES    = 12500    // About 2 kHz tone
) (
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic [3:0] row_in,
    output logic [3:0] col_out,
    output logic       beep,
    output logic [2:0] sel,
    output logic [7:0] seg
);
    logic                         tick;
    logic                         key_valid;
    calc_pkg::key_t               key;
    logic                         start;
    logic                         done;
    logic [calc_pkg::VALUE_W-1:0] operand_a;
    logic [calc_pkg::VALUE_W-1:0] operand_b;
    calc_pkg::op_t                op;
    calc_pkg::result_t            result;
    calc_pkg::result_t            disp;

    tick_timer #(.TICK_CYCLES(TICK_CYCLES)) u_tick_timer (
        .sys_clk(sys_clk), .rst_n(rst_n), .tick(tick)
    );

    key_scan #(.DEBOUNCE_TICKS(DEBOUNCE_TICKS)) u_key_scan (
        .sys_clk(sys_clk), .rst_n(rst_n), .tick(tick), .row_in(row_in),
        .col_out(col_out), .key_valid(key_valid), .key(key)
    );

    calc_ctrl u_calc_ctrl (
        .sys_clk(sys_clk), .rst_n(rst_n), .key_valid(key_valid), .key(key),
        .start(start), .operand_a(operand_a), .operand_b(operand_b), .op(op),
        .done(done), .result(result), .disp(disp)
    );

    calc_alu u_calc_alu (
        .sys_clk(sys_clk), .rst_n(rst_n), .start(start), .operand_a(operand_a),
        .operand_b(operand_b), .op(op), .done(done), .result(result)
    );

    seg_display u_seg_display (
        .sys_clk(sys_clk), .rst_n(rst_n), .tick(tick), .disp(disp),
        .sel(sel), .seg(seg)
    );

    beep_driver #(.BEEP_TICKS(BEEP_TICKS), .TONE_CYCLES(TONE_CYCLES)) u_beep_driver (
        .sys_clk(sys_clk), .rst_n(rst_n), .tick(tick), .key_valid(key_valid), .beep(beep)
    );

endmodule

`default_nettype wire

/* bench/keypad_model.sv */
`default_nettype none

// Behavioral 4x4 matrix keypad, pressing a key shorts its row to its column
module keypad_model (
    input  logic       pressed,
    input  logic [3:0] key_code,        // Row * 4 + column
    input  logic [3:0] col_out,
    output logic [3:0] row_in
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [1:0] row_idx;
    logic [1:0] col_idx;

    assign row_idx = key_code[3:2];
    assign col_idx = key_code[1:0];

    always_comb begin
        row_in = 4'hf;                  // Pull-ups on every row
        if (pressed) begin
            row_in[row_idx] = col_out[col_idx];
        end
    end

endmodule

`default_nettype wire

/* bench/calculator_tb.sv */
`default_nettype none

module calculator_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TICK_CYCLES    = 4;
    localparam int DEBOUNCE_TICKS = 3;
    localparam int BEEP_TICKS     = 4;
    localparam int TONE_CYCLES    = 2;
    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 5;
    localparam int HOLD_TICKS     = 40;
    localparam int MAX_KEYS       = 200;    // Upper bound on presses over all tests
    localparam int WATCHDOG_NS    = MAX_KEYS * 100 * TICK_CYCLES * CLK_PERIOD + 20000;

    logic       sys_clk;
    logic       rst_n;
    logic       pressed;
    logic [3:0] key_code;
    logic [3:0] row_in;
    logic [3:0] col_out;
    logic       beep;
    logic [2:0] sel;
    logic [7:0] seg;
    string      cur_test;
    integer     seed = 32'hb7db_4c05;

    calculator_top #(
        .TICK_CYCLES(TICK_CYCLES),
        .DEBOUNCE_TICKS(DEBOUNCE_TICKS),
        .BEEP_TICKS(BEEP_TICKS),
        .TONE_CYCLES(TONE_CYCLES)
    ) u_calculator_top (
        .sys_clk(sys_clk), .rst_n(rst_n), .row_in(row_in), .col_out(col_out),
        .beep(beep), .sel(sel), .seg(seg)
    );

    keypad_model u_keypad (
        .pressed(pressed), .key_code(key_code), .col_out(col_out), .row_in(row_in)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the tests did not finish in time");
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog timeout");
    end

    task automatic check(input string exp, input string act);
        if (exp != act) begin
            $display("error: test %s expected \"%s\" actual \"%s\"", cur_test, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // Active-low segment patterns
    function automatic byte decode_seg(input logic [7:0] s);
        case (s)
            8'hc0: return "0";
            8'hf9: return "1";
            8'ha4: return "2";
            8'hb0: return "3";
            8'h99: return "4";
            8'h92: return "5";
            8'h82: return "6";
            8'hf8: return "7";
            8'h80: return "8";
            8'h90: return "9";
            8'hff: return " ";
            8'hbf: return "-";
            8'h86: return "E";
            default: return "?";
        endcase
    endfunction

    // Leftmost digit first
    function automatic string expect_disp(input longint mag, input bit neg, input bit err);
        byte    ch[6];
        longint v;
        int     n;
        string  s;
        for (int i = 0; i < 6; i++) ch[i] = " ";
        if (err) begin
            ch[0] = "E";
        end else begin
            v = mag;
            n = 0;
            ch[0] = "0";
            while (v != 0 && n < 6) begin
                ch[n] = byte'(48 + v % 10);
                v = v / 10;
                n++;
            end
            if (n == 0) n = 1;
            if (neg && n < 6) ch[n] = "-";
        end
        s = "";
        for (int i = 5; i >= 0; i--) s = $sformatf("%s%c", s, ch[i]);
        return s;
    endfunction

    // Reference for add, subtract, multiply and divide with sign and overflow
    function automatic string model_calc(input longint a, input longint b, input int opi);
        longint r;
        bit     neg;
        bit     err;
        neg = 1'b0;
        err = 1'b0;
        case (opi)
            0: r = a + b;
            1: begin
                if (a >= b) begin
                    r = a - b;
                end else begin
                    r = b - a;
                    neg = 1'b1;
                end
            end
            2: r = a * b;
            default: begin
                err = (b == 0);
                r = (b == 0) ? 0 : a / b;
            end
        endcase
        if (r > calc_pkg::MAX_VALUE) err = 1'b1;
        return expect_disp(r, neg, err);
    endfunction

    // Held for the first half of the window and released for the second
    task automatic press_key(input int code);
        int         accepted;
        int         toggles;
        logic       last_beep;
        logic [3:0] got_code;
        accepted = 0;
        toggles = 0;
        got_code = 4'hx;
        last_beep = beep;
        pressed = 1'b1;
        key_code = 4'(code);
        for (int i = 0; i < 2 * HOLD_TICKS * TICK_CYCLES; i++) begin
            @(negedge sys_clk);
            if (u_calculator_top.key_valid) begin
                accepted++;
                got_code = u_calculator_top.key.code;
            end
            if (beep != last_beep) toggles++;
            last_beep = beep;
            if (i == HOLD_TICKS * TICK_CYCLES - 1) begin
                pressed = 1'b0;     // Start of the release
            end
        end
        check("1", $sformatf("%0d", accepted));
        check($sformatf("%0d", code), $sformatf("%0d", got_code));
        check("beep toggled", (toggles > 0) ? "beep toggled" : "beep silent");
        check("0", $sformatf("%b", beep));
    endtask

    task automatic type_number(input longint v);
        string s;
        s = $sformatf("%0d", v);
        for (int i = 0; i < s.len(); i++) press_key(s[i] - "0");
    endtask

    task automatic read_display(output string s);
        byte ch[6];
        for (int i = 0; i < 6; i++) ch[i] = "?";
        repeat (2 * calc_pkg::DIGITS * TICK_CYCLES) begin
            @(negedge sys_clk);
            if (sel < 3'd6) ch[sel] = decode_seg(seg);
        end
        s = "";
        for (int i = 5; i >= 0; i--) s = $sformatf("%s%c", s, ch[i]);
    endtask

    task automatic run_calc(input longint a, input int opi, input longint b, input string exp);
        string got;
        press_key(14);
        type_number(a);
        press_key(10 + opi);
        type_number(b);
        press_key(15);
        read_display(got);
        check(exp, got);
    endtask

    task automatic after_reset();
        string got;
        logic  beep_seen;
        cur_test = "reset";
        check("1110", $sformatf("%b", col_out));
        check("0", $sformatf("%0d", sel));
        check("ff", $sformatf("%h", seg));
        beep_seen = 1'b0;
        repeat (20 * TICK_CYCLES) begin
            @(negedge sys_clk);
            if (beep) beep_seen = 1'b1;
        end
        check("0", $sformatf("%b", beep_seen));     // Idle means silent
        read_display(got);
        check("     0", got);
    endtask

    task automatic digit_entry();
        string got;
        cur_test = "entry";
        type_number(16);
        read_display(got);
        check("    16", got);
        press_key(14);
        type_number(1234567);
        read_display(got);
        check("123456", got);
    endtask

    task automatic fixed_arithmetic();
        cur_test = "arith";
        run_calc(16, 2, 4, "    64");
        run_calc(8, 3, 0, "     E");
        run_calc(3, 1, 9, "    -6");
        run_calc(1, 0, 1, "     2");
    endtask

    task automatic random_arithmetic();
        longint a;
        longint b;
        int     opi;
        for (int n = 0; n < 10; n++) begin
            cur_test = $sformatf("random %0d", n);
            a = $unsigned($random(seed)) % (10 ** (1 + $unsigned($random(seed)) % 4));
            b = $unsigned($random(seed)) % (10 ** (1 + $unsigned($random(seed)) % 4));
            opi = $unsigned($random(seed)) % 4;
            run_calc(a, opi, b, model_calc(a, b, opi));
        end
    endtask

    task automatic clear_key();
        string got;
        cur_test = "clear";
        press_key(14);
        type_number(12);
        press_key(14);
        read_display(got);
        check("     0", got);
        type_number(7);
        read_display(got);
        check("     7", got);
        run_calc(2, 0, 3, "     5");
        press_key(14);
        read_display(got);
        check("     0", got);
        type_number(4);
        read_display(got);
        check("     4", got);
    endtask

    task automatic result_reuse();
        string got;
        cur_test = "reuse";
        run_calc(5, 0, 5, "    10");
        press_key(12);              // Multiply on the shown result
        type_number(3);
        press_key(15);
        read_display(got);
        check("    30", got);
    endtask

    initial begin
        rst_n = 1'b0;
        pressed = 1'b0;
        key_code = 4'd0;
        cur_test = "init";
        repeat (RESET_CYCLES) @(negedge sys_clk);
        rst_n = 1'b1;
        after_reset();
        digit_entry();
        fixed_arithmetic();
        random_arithmetic();
        clear_key();
        result_reuse();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
common/calc_pkg.sv
src/tick_timer.sv
keypad/key_scan.sv
src/calc_ctrl.sv
src/calc_alu.sv
display/seg_display.sv
src/beep_driver.sv
src/calculator_top.sv
bench/keypad_model.sv
bench/calculator_tb.sv

/* Bender.yml */
package:
  name: keypad_calculator

sources:
  - common/calc_pkg.sv
  - src/tick_timer.sv
  - keypad/key_scan.sv
  - src/calc_ctrl.sv
  - src/calc_alu.sv
  - display/seg_display.sv
  - src/beep_driver.sv
  - src/calculator_top.sv
  - target: test
    files:
      - bench/keypad_model.sv
      - bench/calculator_tb.sv
